//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_window_buffer
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "tests failed" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/frame_bank.sv
`timescale 1ns/1ps

module frame_bank import window_pkg::*; #(
    parameter int bank_id = 0
) (
    input  logic       clk,
    input  logic       wr_en,
    input  phase_t     wr_bank,
    input  bank_addr_t wr_addr,
    input  pixel_t     wr_data,
    input  col_t       col,
    input  phase_t     phase,
    input  row_t       row_base,
    output pixel_t     rd_data
);

    pixel_t     mem [bank_depth];
    row_t       rd_row;
    bank_addr_t rd_addr;

    // banks below the phase already hold the lower rows of the window.
    assign rd_row  = (phase_t'(bank_id) < phase) ? row_base + 1'b1 : row_base;
    assign rd_addr = bank_addr_t'(rd_row * row_t'(img_w) + row_t'(col));

    always_ff @(posedge clk) begin
        if (wr_en && (wr_bank == phase_t'(bank_id))) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];                        // one cycle read latency.
    end

endmodule

//--- hw/frame_loader.sv
`timescale 1ns/1ps

module frame_loader import window_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pix_valid,
    input  pixel_t     pix_data,
    input  logic       scan_done,
    output logic       wr_en,
    output phase_t     wr_bank,
    output bank_addr_t wr_addr,
    output pixel_t     wr_data,
    output logic       frame_loaded,
    output logic       busy
);

    col_t   col;
    row_t   row;
    phase_t phase;
    row_t   bank_row;
    logic   loaded;                                     // all 256 pixels taken.
    logic   accept;
    logic   last_pix;

    // loaded implies busy, so this covers both the idle and the mid-frame case.
    assign accept   = pix_valid && !loaded;
    assign last_pix = (row == row_t'(img_h - 1)) && (col == col_t'(img_w - 1));

    always_ff @(posedge clk) begin
        if (!rst_n || scan_done) begin
            col      <= '0;
            row      <= '0;
            phase    <= '0;
            bank_row <= '0;
            busy     <= 1'b0;
            loaded   <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
            if (last_pix) begin
                loaded <= 1'b1;
            end
            if (col == col_t'(img_w - 1)) begin
                col <= '0;
                row <= row + 1'b1;
                if (phase == phase_t'(win_size - 1)) begin
                    phase    <= '0;
                    bank_row <= bank_row + 1'b1;     // next pass over the banks.
                end else begin
                    phase <= phase + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en        <= 1'b0;
            frame_loaded <= 1'b0;
        end else begin
            wr_en        <= accept;
            frame_loaded <= accept && last_pix;
        end
    end

    always_ff @(posedge clk) begin
        wr_bank <= phase;
        wr_addr <= bank_addr_t'(bank_row * row_t'(img_w) + row_t'(col));
        wr_data <= pix_data;
    end

endmodule

//--- hw/scan_counter.sv
`timescale 1ns/1ps

module scan_counter import window_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   count_en,
    output col_t   col,
    output phase_t phase,
    output row_t   row_base,
    output logic   col_ge_threshold,
    output logic   col_eq_max,
    output logic   row_eq_max
);

    row_t row;                                          // output row, top of the window.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col      <= '0;
            row      <= '0;
            phase    <= '0;
            row_base <= '0;
        end else if (count_en) begin
            if (col_eq_max) begin
                col <= '0;
                row <= row + 1'b1;
                if (phase == phase_t'(win_size - 1)) begin
                    phase    <= '0;
                    row_base <= row_base + 1'b1;
                end else begin
                    phase <= phase + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    assign col_ge_threshold = (col >= col_t'(win_size - 1));
    assign col_eq_max       = (col == col_t'(img_w - 1));
    assign row_eq_max       = (row == row_t'(out_rows)); // one past the last output row.

endmodule

//--- hw/window_buffer_top.sv
`timescale 1ns/1ps

module window_buffer_top import window_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    pix_valid,
    input  pixel_t  pix_data,
    output logic    busy,
    output window_t window,
    output logic    window_valid,
    output logic    frame_done
);

    logic       wr_en;
    phase_t     wr_bank;
    bank_addr_t wr_addr;
    pixel_t     wr_data;
    logic       frame_loaded;
    logic       count_en;
    logic       win_strobe;
    logic       scan_idle;
    logic       counter_rst_n;
    col_t       col;
    phase_t     phase;
    row_t       row_base;
    logic       col_ge_threshold;
    logic       col_eq_max;
    logic       row_eq_max;
    column_t    bank_data;                              // bank k at element k.

    assign counter_rst_n = rst_n && !scan_idle;         // counters sit at zero between frames.

    frame_loader frame_loader_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_valid    (pix_valid),
        .pix_data     (pix_data),
        .scan_done    (frame_done),
        .wr_en        (wr_en),
        .wr_bank      (wr_bank),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .frame_loaded (frame_loaded),
        .busy         (busy)
    );

    for (genvar k = 0; k < win_size; k++) begin : g_bank
        frame_bank #(
            .bank_id (k)
        ) frame_bank_i (
            .clk      (clk),
            .wr_en    (wr_en),
            .wr_bank  (wr_bank),
            .wr_addr  (wr_addr),
            .wr_data  (wr_data),
            .col      (col),
            .phase    (phase),
            .row_base (row_base),
            .rd_data  (bank_data[k*pix_w +: pix_w])
        );
    end

    scan_counter scan_counter_i (
        .clk              (clk),
        .rst_n            (counter_rst_n),
        .count_en         (count_en),
        .col              (col),
        .phase            (phase),
        .row_base         (row_base),
        .col_ge_threshold (col_ge_threshold),
        .col_eq_max       (col_eq_max),
        .row_eq_max       (row_eq_max)
    );

    window_controller window_controller_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .done_i           (frame_loaded),
        .row_eq_max       (row_eq_max),
        .col_eq_max       (col_eq_max),
        .col_ge_threshold (col_ge_threshold),
        .count_en         (count_en),
        .win_strobe       (win_strobe),
        .scan_done        (frame_done),
        .scan_idle        (scan_idle)
    );

    window_shift window_shift_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .bank_data    (bank_data),
        .phase        (phase),
        .win_strobe   (win_strobe),
        .window       (window),
        .window_valid (window_valid)
    );

endmodule

//--- hw/window_controller.sv
`timescale 1ns/1ps

module window_controller import window_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic done_i,
    input  logic row_eq_max,
    input  logic col_eq_max,
    input  logic col_ge_threshold,
    output logic count_en,
    output logic win_strobe,
    output logic scan_done,
    output logic scan_idle
);

    scan_state_t state;
    scan_state_t next_state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= idle;
            scan_done <= 1'b0;
        end else begin
            state     <= next_state;
            scan_done <= (state == finish_all);     // lands after the last window_valid.
        end
    end

    always_comb begin
        next_state = idle;
        case (state)
            idle:       next_state = done_i ? start : idle;
            start:      next_state = start_col;
            start_col: begin
                if (row_eq_max) begin
                    next_state = finish_all;
                end else if (col_ge_threshold) begin
                    next_state = col_out;
                end else begin
                    next_state = start_col;
                end
            end
            col_out: begin
                if (row_eq_max) begin
                    next_state = finish_all;
                end else if (col_eq_max) begin
                    next_state = end_col;
                end else begin
                    next_state = col_out;
                end
            end
            end_col:    next_state = row_eq_max ? finish_all : end_col_2;
            end_col_2:  next_state = row_eq_max ? finish_all : start_col;
            finish_all: next_state = done;
            done:       next_state = idle;
            default:    next_state = idle;
        endcase
    end

    // first 11 reads fill the window, the rest each complete one.
    assign count_en   = (state == start_col) || (state == col_out);
    assign win_strobe = (state == col_out) || (state == end_col);
    assign scan_idle  = (state == idle);

endmodule

//--- hw/window_pkg.sv
package window_pkg;

    localparam int pix_w      = 8;
    localparam int img_w      = 16;
    localparam int img_h      = 16;
    localparam int win_size   = 11;                     // window edge and bank count.
    localparam int out_rows   = img_h - win_size + 1;
    localparam int bank_rows  = 2;                      // image rows held per bank.
    localparam int bank_depth = bank_rows * img_w;

    typedef logic [pix_w-1:0] pixel_t;
    typedef logic [3:0]       col_t;
    typedef logic [4:0]       row_t;
    typedef logic [4:0]       bank_addr_t;
    typedef logic [3:0]       phase_t;                  // image row mod 11.

    typedef logic [win_size*pix_w-1:0]          column_t;  // element 0 is the top pixel.
    typedef logic [win_size*win_size*pix_w-1:0] window_t;  // element i*11+j is row i, col j.

    typedef enum logic [2:0] {
        idle,
        start,
        start_col,
        col_out,
        end_col,
        end_col_2,
        finish_all,
        done
    } scan_state_t;

endpackage

//--- hw/window_shift.sv
`timescale 1ns/1ps

module window_shift import window_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  column_t bank_data,
    input  phase_t  phase,
    input  logic    win_strobe,
    output window_t window,
    output logic    window_valid
);

    phase_t  phase_d;                                   // phase of the read now on bank_data.
    column_t ordered;

    always_ff @(posedge clk) begin
        phase_d <= phase;
    end

    // window row i comes from bank (phase + i) mod 11.
    always_comb begin
        int src;
        ordered = '0;
        for (int i = 0; i < win_size; i++) begin
            src = int'(phase_d) + i;
            if (src >= win_size) begin
                src = src - win_size;
            end
            ordered[i*pix_w +: pix_w] = bank_data[src*pix_w +: pix_w];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < win_size; i++) begin
            for (int j = 0; j < win_size - 1; j++) begin
                window[(i*win_size + j)*pix_w +: pix_w] <=
                    window[(i*win_size + j + 1)*pix_w +: pix_w];
            end
            window[(i*win_size + win_size - 1)*pix_w +: pix_w] <= ordered[i*pix_w +: pix_w];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            window_valid <= 1'b0;
        end else begin
            window_valid <= win_strobe;
        end
    end

endmodule

//--- tb.f
hw/window_pkg.sv
hw/frame_loader.sv
hw/frame_bank.sv
hw/scan_counter.sv
hw/window_controller.sv
hw/window_shift.sv
hw/window_buffer_top.sv
verif/window_asserts.sv
verif/window_checker.sv
verif/tb_window_buffer.sv

//--- verif/tb_window_buffer.sv
`timescale 1ns/1ps

module tb_window_buffer import window_pkg::*; ();

    localparam int num_frames     = 3;
    localparam int load_cycles    = 1024;               // generous for 256 pixels at 3/4 rate.
    localparam int scan_cycles    = 120;
    localparam int timeout_cycles =
        ((num_frames * (load_cycles + scan_cycles) + 999) / 1000) * 1000;
    localparam int frame_windows  = out_rows * (img_w - win_size + 1);

    logic        clk = 1'b0;
    logic        rst_n;
    logic        pix_valid;
    pixel_t      pix_data;
    logic        busy;
    window_t     window;
    logic        window_valid;
    logic        frame_done;
    int          error_count;
    int          window_total;
    int          frame_count;
    int          run_errors  = 0;
    int          cycle_count = 0;
    logic [31:0] lfsr        = 32'h79ab_077a;

    always #20 clk = ~clk;

    // one galois shift for each bit taken.
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd000_0001) : (lfsr >> 1);
        end
        return bits;
    endfunction

    window_buffer_top window_buffer_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_valid    (pix_valid),
        .pix_data     (pix_data),
        .busy         (busy),
        .window       (window),
        .window_valid (window_valid),
        .frame_done   (frame_done)
    );

    window_checker window_checker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_valid    (pix_valid),
        .pix_data     (pix_data),
        .busy         (busy),
        .window       (window),
        .window_valid (window_valid),
        .frame_done   (frame_done),
        .error_count  (error_count),
        .window_total (window_total),
        .frame_count  (frame_count)
    );

    bind window_buffer_top window_asserts window_asserts_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .busy         (busy),
        .window_valid (window_valid),
        .frame_done   (frame_done)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: only %0d of %0d frames finished in %0d cycles",
                     frame_count, num_frames, timeout_cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        rst_n     = 1'b0;
        pix_valid = 1'b0;
        pix_data  = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        // pixels keep coming while a frame is scanned and the DUT drops them.
        while (frame_count < num_frames) begin
            @(posedge clk);
            pix_valid <= (rand_bits(2) != 8'h00);
            pix_data  <= rand_bits(8);
        end
        pix_valid <= 1'b0;
        repeat (4) @(posedge clk);
        if (window_total != num_frames * frame_windows) begin
            $display("wrong number of windows: %0d instead of %0d",
                     window_total, num_frames * frame_windows);
            run_errors++;
        end
        $display("errors %0d (checker %0d, run %0d), windows %0d, frames %0d",
                 error_count + run_errors, error_count, run_errors, window_total, frame_count);
        if ((error_count + run_errors) == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- verif/window_asserts.sv
`timescale 1ns/1ps

module window_asserts (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic window_valid,
    input logic frame_done
);

    // the last window lands one cycle ahead of the done pulse.
    valid_done_apart: assert property (
        @(posedge clk) disable iff (!rst_n) !(window_valid && frame_done)
    ) else $error("window_valid and frame_done were high in the same cycle");

    done_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) frame_done |=> !frame_done
    ) else $error("frame_done stayed high for more than one cycle");

    busy_clears_after_done: assert property (
        @(posedge clk) disable iff (!rst_n) frame_done |=> !busy
    ) else $error("busy still high in the cycle after frame_done");

    valid_only_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) window_valid |-> busy
    ) else $error("window_valid was high while busy was low");

endmodule

//--- verif/window_checker.sv
`timescale 1ns/1ps

module window_checker import window_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    pix_valid,
    input  pixel_t  pix_data,
    input  logic    busy,
    input  window_t window,
    input  logic    window_valid,
    input  logic    frame_done,
    output int      error_count,
    output int      window_total,
    output int      frame_count
);

    localparam int frame_pixels  = img_w * img_h;
    localparam int out_cols      = img_w - win_size + 1;
    localparam int frame_windows = out_rows * out_cols;

    pixel_t model [frame_pixels];                       // raster copy of the loaded frame.
    int     loaded_count;
    int     win_in_frame;
    logic   exp_busy;

    task automatic compare_window(input int r, input int c);
        pixel_t expected;
        pixel_t actual;
        for (int i = 0; i < win_size; i++) begin
            for (int j = 0; j < win_size; j++) begin
                expected = model[(r + i) * img_w + c + j];
                actual   = window[(i * win_size + j) * pix_w +: pix_w];
                if (actual !== expected) begin
                    $display("mismatch window[%0d] at r %0d c %0d: expected %h, got %h",
                             i * win_size + j, r, c, expected, actual);
                    error_count++;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            loaded_count = 0;
            win_in_frame = 0;
            exp_busy     = 1'b0;
            error_count  = 0;
            window_total <= 0;
            frame_count  <= 0;
        end else begin
            if (busy !== exp_busy) begin
                $display("mismatch busy: expected %h, got %h", exp_busy, busy);
                error_count++;
            end
            if (window_valid) begin
                if (loaded_count != frame_pixels) begin
                    $display("window shown before the frame was fully loaded");
                    error_count++;
                end else if (win_in_frame >= frame_windows) begin
                    $display("more than %0d windows in one frame", frame_windows);
                    error_count++;
                end else begin
                    compare_window(win_in_frame / out_cols, win_in_frame % out_cols);
                end
                win_in_frame++;
                window_total <= window_total + 1;
            end
            // the loader clears on the done pulse, so no pixel is taken in that cycle.
            if (frame_done) begin
                if (win_in_frame != frame_windows) begin
                    $display("frame ended after %0d windows instead of %0d",
                             win_in_frame, frame_windows);
                    error_count++;
                end
                frame_count  <= frame_count + 1;
                loaded_count = 0;
                win_in_frame = 0;
                exp_busy     = 1'b0;
            end else if (pix_valid && (loaded_count < frame_pixels)) begin
                model[loaded_count] = pix_data;
                loaded_count++;
                exp_busy = 1'b1;
            end
        end
    end

endmodule
